// ==== verilog/msx_cart_pkg.sv ====
`default_nettype none

package msx_cart_pkg;

    // Largest number of cartridge slots with their own bank registers
    parameter int MAX_SLOTS = 2;

    // Width of the slot number carried in the block info
    parameter int SLOT_W = $clog2(MAX_SLOTS);

    // ROM size in bytes, SRAM size in KB
    parameter int ROM_SIZE_W  = 25;
    parameter int SRAM_SIZE_W = 16;

    // Cartridge mapper type
    typedef enum logic [2:0] {
        MAPPER_NONE    = 3'd0,
        MAPPER_ASCII8  = 3'd1,
        MAPPER_KOEI    = 3'd2,
        MAPPER_WIZARDY = 3'd3,
        MAPPER_ASCII16 = 3'd4
    } mapper_typ_t;

    // Description of the inserted cartridge
    typedef struct packed {
        mapper_typ_t             typ;
        logic [SLOT_W-1:0]       id;
        logic [ROM_SIZE_W-1:0]   rom_size;
        logic [SRAM_SIZE_W-1:0]  sram_size;
    } block_info_t;

endpackage

`default_nettype wire

// ==== verilog/msx_mem_pkg.sv ====
`default_nettype none

package msx_mem_pkg;

    // Physical address into cartridge ROM or SRAM
    parameter int MEM_ADDR_W = 27;

    // Z80 side address
    parameter int CPU_ADDR_W = 16;

    // Address driven when no memory is selected
    parameter logic [MEM_ADDR_W-1:0] IDLE_ADDR = '1;

endpackage

`default_nettype wire

// ==== verilog/cpu_bus_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface cpu_bus_if
    import msx_mem_pkg::*;
();

    logic [CPU_ADDR_W-1:0] addr;
    logic [7:0]            data;
    logic                  rd;
    logic                  wr;
    logic                  mreq;

    // Top level drives the bus
    modport master (
        output addr, data, rd, wr, mreq
    );

    // Mapper engines only watch it
    modport slave (
        input addr, data, rd, wr, mreq
    );

endinterface

`default_nettype wire

// ==== verilog/mapper_out_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface mapper_out_if
    import msx_mem_pkg::*;
();

    logic [MEM_ADDR_W-1:0] addr;
    logic                  ram_cs;
    logic                  sram_cs;
    logic                  rnw;

    // Driven by one mapper engine
    modport source (
        output addr, ram_cs, sram_cs, rnw
    );

    // Read by the output mux
    modport sink (
        input addr, ram_cs, sram_cs, rnw
    );

endinterface

`default_nettype wire

// ==== verilog/mapper_ascii8.sv ====
`timescale 1ns/1ps
`default_nettype none

module mapper_ascii8
    import msx_cart_pkg::*;
    import msx_mem_pkg::*;
#(
    parameter int NUM_SLOTS = 2
) (
    input  logic          clock_bus,
    input  logic          rst,
    cpu_bus_if.slave      cpu,
    input  block_info_t   info,
    mapper_out_if.source  out
);

    logic                  mapped;
    logic                  mapper_en;
    logic                  mode_wizardy;
    logic                  mode_koei;
    logic                  cs;
    logic                  ctrl_wr;
    logic                  sram_exists;
    logic [7:0]            sram_mask;
    logic [7:0]            sram_enable_bit;
    logic [3:0]            sram_regions;
    logic [1:0]            wr_region;
    logic [1:0]            acc_region;
    logic                  sram_sel;
    logic                  sram_hit;
    logic [MEM_ADDR_W-1:0] rom_addr;
    logic [MEM_ADDR_W-1:0] sram_addr;
    logic                  rom_valid;
    logic                  sram_cs;

    // Four 8 KB region banks per slot
    logic [7:0] rom_bank  [NUM_SLOTS][4];
    logic [7:0] sram_bank [NUM_SLOTS][4];
    logic [3:0] sram_en   [NUM_SLOTS];

    // Only 4000h-BFFFh is banked
    assign mapped       = ^cpu.addr[15:14];
    assign mode_wizardy = (info.typ == MAPPER_WIZARDY);
    assign mode_koei    = (info.typ == MAPPER_KOEI);
    assign mapper_en    = (info.typ == MAPPER_ASCII8) | mode_koei | mode_wizardy;
    assign cs           = mapped & mapper_en & cpu.mreq;

    // Bank register window at 6000h-7FFFh
    assign ctrl_wr   = cs & cpu.wr & (cpu.addr[15:13] == 3'b011);
    assign wr_region = cpu.addr[12:11];

    // 4000h, 6000h, 8000h, A000h map to regions 0..3
    assign acc_region = {cpu.addr[15], cpu.addr[13]};

    assign sram_exists = (info.sram_size != '0);
    assign sram_mask   = (info.sram_size[10:3] != 8'd0) ? (info.sram_size[10:3] - 8'd1) : 8'd0;

    // ROM size in 8 KB banks gives the first bit past the bank range
    assign sram_enable_bit = mode_wizardy ? 8'h80 : info.rom_size[20:13];
    assign sram_regions    = mode_koei ? 4'b1111 : 4'b1100;

    assign sram_sel = ((cpu.data & sram_enable_bit) != 8'd0) & sram_exists &
                      sram_regions[wr_region];

    always_ff @(posedge clock_bus) begin
        if (rst) begin
            for (int s = 0; s < NUM_SLOTS; s++) begin
                for (int r = 0; r < 4; r++) begin
                    rom_bank[s][r]  <= '0;
                    sram_bank[s][r] <= '0;
                end
                sram_en[s] <= '0;
            end
        end else if (ctrl_wr) begin
            if (sram_sel) begin
                sram_en[info.id][wr_region]   <= 1'b1;
                sram_bank[info.id][wr_region] <= cpu.data & sram_mask;
            end else begin
                sram_en[info.id][wr_region]  <= 1'b0;
                rom_bank[info.id][wr_region] <= cpu.data;
            end
        end
    end

    // Translation for the current access
    assign sram_hit  = sram_en[info.id][acc_region];
    assign rom_addr  = MEM_ADDR_W'({rom_bank[info.id][acc_region], cpu.addr[12:0]});
    assign sram_addr = MEM_ADDR_W'({sram_bank[info.id][acc_region], cpu.addr[12:0]});
    assign rom_valid = (rom_addr < MEM_ADDR_W'(info.rom_size));

    assign sram_cs = cs & sram_hit;

    assign out.sram_cs = sram_cs;
    assign out.ram_cs  = cs & rom_valid & ~sram_hit & cpu.rd;
    // SRAM is the only writable target
    assign out.rnw     = ~(sram_cs & cpu.wr);
    assign out.addr    = cs ? (sram_hit ? sram_addr : rom_addr) : IDLE_ADDR;

endmodule

`default_nettype wire

// ==== verilog/mapper_ascii16.sv ====
`timescale 1ns/1ps
`default_nettype none

module mapper_ascii16
    import msx_cart_pkg::*;
    import msx_mem_pkg::*;
#(
    parameter int NUM_SLOTS = 2
) (
    input  logic          clock_bus,
    input  logic          rst,
    cpu_bus_if.slave      cpu,
    input  block_info_t   info,
    mapper_out_if.source  out
);

    logic                  mapped;
    logic                  cs;
    logic                  ctrl_wr;
    logic                  wr_page;
    logic                  acc_page;
    logic                  sram_exists;
    logic [7:0]            sram_mask;
    logic [7:0]            sram_enable_bit;
    logic                  sram_sel;
    logic                  sram_hit;
    logic [MEM_ADDR_W-1:0] rom_addr;
    logic [MEM_ADDR_W-1:0] sram_addr;
    logic                  rom_valid;
    logic                  sram_cs;

    // Two 16 KB page banks per slot
    logic [7:0] rom_bank  [NUM_SLOTS][2];
    logic [7:0] sram_bank [NUM_SLOTS][2];
    logic [1:0] sram_en   [NUM_SLOTS];

    assign mapped = ^cpu.addr[15:14];
    assign cs     = mapped & (info.typ == MAPPER_ASCII16) & cpu.mreq;

    // 6000h-67FFh selects page 0, 7000h-77FFh page 1
    assign ctrl_wr  = cs & cpu.wr & (cpu.addr[15:13] == 3'b011) & ~cpu.addr[11];
    assign wr_page  = cpu.addr[12];
    assign acc_page = cpu.addr[15];

    assign sram_exists = (info.sram_size != '0);
    assign sram_mask   = (info.sram_size[11:4] != 8'd0) ? (info.sram_size[11:4] - 8'd1) : 8'd0;

    // ROM size in 16 KB banks marks the SRAM switch bit
    assign sram_enable_bit = info.rom_size[21:14];
    assign sram_sel        = ((cpu.data & sram_enable_bit) != 8'd0) & sram_exists;

    always_ff @(posedge clock_bus) begin
        if (rst) begin
            for (int s = 0; s < NUM_SLOTS; s++) begin
                for (int p = 0; p < 2; p++) begin
                    rom_bank[s][p]  <= '0;
                    sram_bank[s][p] <= '0;
                end
                sram_en[s] <= '0;
            end
        end else if (ctrl_wr) begin
            if (sram_sel) begin
                sram_en[info.id][wr_page]   <= 1'b1;
                sram_bank[info.id][wr_page] <= cpu.data & sram_mask;
            end else begin
                sram_en[info.id][wr_page]  <= 1'b0;
                rom_bank[info.id][wr_page] <= cpu.data;
            end
        end
    end

    assign sram_hit  = sram_en[info.id][acc_page];
    assign rom_addr  = MEM_ADDR_W'({rom_bank[info.id][acc_page], cpu.addr[13:0]});
    assign sram_addr = MEM_ADDR_W'({sram_bank[info.id][acc_page], cpu.addr[13:0]});
    assign rom_valid = (rom_addr < MEM_ADDR_W'(info.rom_size));

    assign sram_cs = cs & sram_hit;

    assign out.sram_cs = sram_cs;
    assign out.ram_cs  = cs & rom_valid & ~sram_hit & cpu.rd;
    assign out.rnw     = ~(sram_cs & cpu.wr);
    assign out.addr    = cs ? (sram_hit ? sram_addr : rom_addr) : IDLE_ADDR;

endmodule

`default_nettype wire

// ==== verilog/mapper_output_mux.sv ====
`timescale 1ns/1ps
`default_nettype none

module mapper_output_mux
    import msx_mem_pkg::*;
(
    mapper_out_if.sink             a,
    mapper_out_if.sink             b,
    output logic [MEM_ADDR_W-1:0]  mem_addr,
    output logic                   ram_cs,
    output logic                   sram_cs,
    output logic                   rnw
);

    logic a_sel;
    logic b_sel;
    logic a_drv;
    logic b_drv;

    assign a_sel = a.ram_cs | a.sram_cs;
    assign b_sel = b.ram_cs | b.sram_cs;

    // An engine decoding its page drives a real address even without a select
    assign a_drv = (a.addr != IDLE_ADDR);
    assign b_drv = (b.addr != IDLE_ADDR);

    // Engine a has priority on overlap
    always_comb begin
        if (a_sel || (!b_sel && a_drv)) begin
            mem_addr = a.addr;
            ram_cs   = a.ram_cs;
            sram_cs  = a.sram_cs;
            rnw      = a.rnw;
        end else if (b_sel || b_drv) begin
            mem_addr = b.addr;
            ram_cs   = b.ram_cs;
            sram_cs  = b.sram_cs;
            rnw      = b.rnw;
        end else begin
            mem_addr = IDLE_ADDR;
            ram_cs   = 1'b0;
            sram_cs  = 1'b0;
            rnw      = 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/msx_cart_mapper.sv ====
`timescale 1ns/1ps
`default_nettype none

module msx_cart_mapper
    import msx_cart_pkg::*;
    import msx_mem_pkg::*;
#(
    parameter int NUM_SLOTS = MAX_SLOTS
) (
    input  logic                    clock_bus,
    input  logic                    rst,

    input  logic [CPU_ADDR_W-1:0]   cpu_addr,
    input  logic [7:0]              cpu_data,
    input  logic                    cpu_rd,
    input  logic                    cpu_wr,
    input  logic                    cpu_mreq,

    input  mapper_typ_t             cart_type,
    input  logic [SLOT_W-1:0]       cart_id,
    input  logic [ROM_SIZE_W-1:0]   rom_size,
    input  logic [SRAM_SIZE_W-1:0]  sram_size,

    output logic [MEM_ADDR_W-1:0]   mem_addr,
    output logic                    ram_cs,
    output logic                    sram_cs,
    output logic                    rnw
);

    block_info_t info;

    cpu_bus_if    bus ();
    mapper_out_if out_a ();
    mapper_out_if out_b ();

    assign bus.addr = cpu_addr;
    assign bus.data = cpu_data;
    assign bus.rd   = cpu_rd;
    assign bus.wr   = cpu_wr;
    assign bus.mreq = cpu_mreq;

    assign info = '{typ: cart_type, id: cart_id, rom_size: rom_size, sram_size: sram_size};

    // Both engines see every cycle and decode the type themselves
    mapper_ascii8 #(
        .NUM_SLOTS (NUM_SLOTS)
    ) i_ascii8 (
        .clock_bus (clock_bus),
        .rst       (rst),
        .cpu       (bus.slave),
        .info      (info),
        .out       (out_a.source)
    );

    mapper_ascii16 #(
        .NUM_SLOTS (NUM_SLOTS)
    ) i_ascii16 (
        .clock_bus (clock_bus),
        .rst       (rst),
        .cpu       (bus.slave),
        .info      (info),
        .out       (out_b.source)
    );

    mapper_output_mux i_out_mux (
        .a        (out_a.sink),
        .b        (out_b.sink),
        .mem_addr (mem_addr),
        .ram_cs   (ram_cs),
        .sram_cs  (sram_cs),
        .rnw      (rnw)
    );

endmodule

`default_nettype wire

// ==== test/tb_mapper_model.svh ====
`ifndef TB_MAPPER_MODEL_SVH
`define TB_MAPPER_MODEL_SVH

// Bank state per slot for the four ASCII8 regions and the two ASCII16 pages
logic [7:0] rom_bank8   [NUM_SLOTS][4];
logic [7:0] sram_bank8  [NUM_SLOTS][4];
logic       sram_on8    [NUM_SLOTS][4];
logic [7:0] rom_bank16  [NUM_SLOTS][2];
logic [7:0] sram_bank16 [NUM_SLOTS][2];
logic       sram_on16   [NUM_SLOTS][2];

function automatic logic uses_ascii8(input mapper_typ_t t);
    return (t == MAPPER_ASCII8) || (t == MAPPER_KOEI) || (t == MAPPER_WIZARDY);
endfunction

// Number of banks of 2**shift units in n, cut to the 8-bit bank range
function automatic logic [7:0] bank_count(input logic [31:0] n, input int shift);
    logic [31:0] q;
    q = n >> shift;
    return q[7:0];
endfunction

function automatic logic [7:0] bank_mask(input logic [7:0] count);
    return (count == 8'd0) ? 8'd0 : count - 8'd1;
endfunction

// Register writes taken at one rising edge
task automatic apply_edge();
    logic [7:0] enable_bit;
    logic [7:0] mask;
    logic [1:0] r;
    logic       p;
    logic       to_sram;
    if (rst) begin
        for (int s = 0; s < NUM_SLOTS; s++) begin
            for (int w = 0; w < 4; w++) begin
                rom_bank8[s][w]  = 8'd0;
                sram_bank8[s][w] = 8'd0;
                sram_on8[s][w]   = 1'b0;
            end
            for (int w = 0; w < 2; w++) begin
                rom_bank16[s][w]  = 8'd0;
                sram_bank16[s][w] = 8'd0;
                sram_on16[s][w]   = 1'b0;
            end
        end
    end else if (cpu_mreq && cpu_wr && uses_ascii8(cart_type) &&
                 cpu_addr >= 16'h6000 && cpu_addr <= 16'h7FFF) begin
        r          = cpu_addr[12:11];
        enable_bit = (cart_type == MAPPER_WIZARDY) ? 8'h80 : bank_count(32'(rom_size), 13);
        to_sram    = ((cpu_data & enable_bit) != 8'd0) && (sram_size != 16'd0) &&
                     (cart_type == MAPPER_KOEI || r >= 2'd2);
        mask       = bank_mask(bank_count(32'(sram_size), 3));
        sram_on8[cart_id][r] = to_sram;
        if (to_sram) begin
            sram_bank8[cart_id][r] = cpu_data & mask;
        end else begin
            rom_bank8[cart_id][r] = cpu_data;
        end
    end else if (cpu_mreq && cpu_wr && cart_type == MAPPER_ASCII16 &&
                 ((cpu_addr >= 16'h6000 && cpu_addr < 16'h6800) ||
                  (cpu_addr >= 16'h7000 && cpu_addr < 16'h7800))) begin
        p          = (cpu_addr >= 16'h7000);
        enable_bit = bank_count(32'(rom_size), 14);
        to_sram    = ((cpu_data & enable_bit) != 8'd0) && (sram_size != 16'd0);
        mask       = bank_mask(bank_count(32'(sram_size), 4));
        sram_on16[cart_id][p] = to_sram;
        if (to_sram) begin
            sram_bank16[cart_id][p] = cpu_data & mask;
        end else begin
            rom_bank16[cart_id][p] = cpu_data;
        end
    end
endtask

// Outputs for the inputs currently on the bus
task automatic expected_outputs(output logic [MEM_ADDR_W-1:0] addr, output logic ram,
                                output logic sram, output logic rw);
    logic [15:0]           off;
    logic                  hit;
    logic                  active;
    logic [MEM_ADDR_W-1:0] rom_a;
    logic [MEM_ADDR_W-1:0] sram_a;
    off    = cpu_addr - 16'h4000;
    active = 1'b0;
    hit    = 1'b0;
    rom_a  = '0;
    sram_a = '0;
    if (cpu_mreq && cpu_addr >= 16'h4000 && cpu_addr < 16'hC000) begin
        if (uses_ascii8(cart_type)) begin
            active = 1'b1;
            hit    = sram_on8[cart_id][off[14:13]];
            rom_a  = {6'd0, rom_bank8[cart_id][off[14:13]], cpu_addr[12:0]};
            sram_a = {6'd0, sram_bank8[cart_id][off[14:13]], cpu_addr[12:0]};
        end else if (cart_type == MAPPER_ASCII16) begin
            active = 1'b1;
            hit    = sram_on16[cart_id][off[14]];
            rom_a  = {5'd0, rom_bank16[cart_id][off[14]], cpu_addr[13:0]};
            sram_a = {5'd0, sram_bank16[cart_id][off[14]], cpu_addr[13:0]};
        end
    end
    addr = IDLE_ADDR;
    ram  = 1'b0;
    sram = 1'b0;
    rw   = 1'b1;
    if (active) begin
        addr = hit ? sram_a : rom_a;
        sram = hit;
        ram  = !hit && cpu_rd && (rom_a < {2'd0, rom_size});
        rw   = !(hit && cpu_wr);
    end
endtask

`endif

// ==== test/tb_msx_cart_mapper.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_msx_cart_mapper
    import msx_cart_pkg::*;
    import msx_mem_pkg::*;
();

    localparam int NUM_SLOTS    = 2;
    localparam int RESET_CYCLES = 4;
    localparam int TEST_CYCLES  = 400;
    localparam int NUM_TESTS    = 9;
    // Every test fits in reset, setup and its random cycles, 4 ns each
    localparam int LIMIT_NS = NUM_TESTS * (TEST_CYCLES + RESET_CYCLES + 2) * 4 + 400;

    logic                   clock_bus = 1'b0;
    logic                   rst;
    logic [CPU_ADDR_W-1:0]  cpu_addr;
    logic [7:0]             cpu_data;
    logic                   cpu_rd;
    logic                   cpu_wr;
    logic                   cpu_mreq;
    mapper_typ_t            cart_type;
    logic [SLOT_W-1:0]      cart_id;
    logic [ROM_SIZE_W-1:0]  rom_size;
    logic [SRAM_SIZE_W-1:0] sram_size;
    logic [MEM_ADDR_W-1:0]  mem_addr;
    logic                   ram_cs;
    logic                   sram_cs;
    logic                   rnw;

    integer seed;
    int     errors;
    int     checks;
    logic   checking;
    string  test_name;

    `include "tb_mapper_model.svh"

    msx_cart_mapper #(
        .NUM_SLOTS (NUM_SLOTS)
    ) i_dut (
        .clock_bus (clock_bus),
        .rst       (rst),
        .cpu_addr  (cpu_addr),
        .cpu_data  (cpu_data),
        .cpu_rd    (cpu_rd),
        .cpu_wr    (cpu_wr),
        .cpu_mreq  (cpu_mreq),
        .cart_type (cart_type),
        .cart_id   (cart_id),
        .rom_size  (rom_size),
        .sram_size (sram_size),
        .mem_addr  (mem_addr),
        .ram_cs    (ram_cs),
        .sram_cs   (sram_cs),
        .rnw       (rnw)
    );

    always #2 clock_bus = ~clock_bus;

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %s %s: expected %h, actual %h", test_name, what, expected, actual);
        end
    endtask

    task automatic compare_outputs();
        logic [MEM_ADDR_W-1:0] exp_addr;
        logic                  exp_ram;
        logic                  exp_sram;
        logic                  exp_rnw;
        expected_outputs(exp_addr, exp_ram, exp_sram, exp_rnw);
        check_value("mem_addr", 32'(exp_addr), 32'(mem_addr));
        check_value("ram_cs", 32'(exp_ram), 32'(ram_cs));
        check_value("sram_cs", 32'(exp_sram), 32'(sram_cs));
        check_value("rnw", 32'(exp_rnw), 32'(rnw));
    endtask

    // Model follows the edge, outputs are compared mid cycle
    always @(posedge clock_bus) apply_edge();

    always @(negedge clock_bus) begin
        if (checking) begin
            compare_outputs();
        end
    end

    task automatic apply_reset();
        @(posedge clock_bus);
        rst      <= 1'b1;
        cpu_mreq <= 1'b0;
        cpu_rd   <= 1'b0;
        cpu_wr   <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clock_bus);
        rst <= 1'b0;
    endtask

    task automatic bus_cycle(input logic flip_slot);
        logic [31:0] r;
        logic [31:0] d;
        r = $random(seed);
        d = $random(seed);
        @(posedge clock_bus);
        if (flip_slot) begin
            cart_id <= ~cart_id;
        end
        cpu_mreq <= (r[31:29] != 3'd0);
        cpu_data <= d[7:0];
        if (r[28:27] == 2'd0) begin
            // Aim at the bank register window
            cpu_addr <= {3'b011, r[12:0]};
            cpu_rd   <= 1'b0;
            cpu_wr   <= 1'b1;
        end else begin
            cpu_addr <= r[15:0];
            cpu_rd   <= r[26];
            cpu_wr   <= ~r[26];
        end
    endtask

    task automatic run_test(input string name, input mapper_typ_t t, input logic no_sram,
                            input logic swap_slots);
        logic [31:0] r;
        test_name = name;
        r = $random(seed);
        @(posedge clock_bus);
        cart_type <= t;
        cart_id   <= r[6];
        // ROM up to 256 KB keeps the SRAM switch bit inside the data byte
        // and leaves bank numbers that point past the ROM end
        rom_size  <= 25'd32768 << r[1:0];
        sram_size <= no_sram ? 16'd0 : (16'd8 << r[4:3]);
        apply_reset();
        for (int i = 0; i < TEST_CYCLES; i++) begin
            bus_cycle(swap_slots && (i % 25 == 24));
        end
    endtask

    task automatic reset_state_test();
        logic [31:0] r;
        logic [15:0] a;
        test_name = "reset_state";
        @(posedge clock_bus);
        cart_type <= MAPPER_ASCII8;
        cart_id   <= '0;
        rom_size  <= 25'h20000;
        sram_size <= 16'd0;
        apply_reset();
        for (int i = 0; i < 16; i++) begin
            r = $random(seed);
            a = {1'b0, r[15:1]} + 16'h4000;
            @(posedge clock_bus);
            cpu_addr <= a;
            cpu_rd   <= 1'b1;
            cpu_wr   <= 1'b0;
            cpu_mreq <= 1'b1;
            @(negedge clock_bus);
            check_value("bank 0 address", 32'(a[12:0]), 32'(mem_addr));
            check_value("bank 0 ram_cs", 32'd1, 32'(ram_cs));
            check_value("bank 0 sram_cs", 32'd0, 32'(sram_cs));
        end
        @(posedge clock_bus);
        cpu_mreq <= 1'b0;
        @(negedge clock_bus);
        check_value("idle address", 32'(IDLE_ADDR), 32'(mem_addr));
        check_value("idle ram_cs", 32'd0, 32'(ram_cs));
        check_value("idle sram_cs", 32'd0, 32'(sram_cs));
        check_value("idle rnw", 32'd1, 32'(rnw));
    endtask

    initial begin
        seed      = 32'h97630516;
        errors    = 0;
        checks    = 0;
        checking  = 1'b1;
        test_name = "startup";
        rst       <= 1'b1;
        cpu_addr  <= '0;
        cpu_data  <= '0;
        cpu_rd    <= 1'b0;
        cpu_wr    <= 1'b0;
        cpu_mreq  <= 1'b0;
        cart_type <= MAPPER_NONE;
        cart_id   <= '0;
        rom_size  <= '0;
        sram_size <= '0;
        reset_state_test();
        run_test("ascii8_banking", MAPPER_ASCII8, 1'b0, 1'b0);
        run_test("koei_banking", MAPPER_KOEI, 1'b0, 1'b0);
        run_test("wizardy_banking", MAPPER_WIZARDY, 1'b0, 1'b0);
        run_test("ascii16_banking", MAPPER_ASCII16, 1'b0, 1'b0);
        run_test("range_no_mapper", MAPPER_NONE, 1'b0, 1'b0);
        run_test("range_no_sram", MAPPER_ASCII8, 1'b1, 1'b0);
        run_test("slots_koei", MAPPER_KOEI, 1'b0, 1'b1);
        run_test("slots_ascii16", MAPPER_ASCII16, 1'b0, 1'b1);
        @(posedge clock_bus);
        checking = 1'b0;
        $display("Closing report: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        #(LIMIT_NS);
        $display("Watchdog timeout: the run did not finish within %0d ns", LIMIT_NS);
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== msx_cart_mapper.f ====
+incdir+test
verilog/msx_cart_pkg.sv
verilog/msx_mem_pkg.sv
verilog/cpu_bus_if.sv
verilog/mapper_out_if.sv
verilog/mapper_ascii8.sv
verilog/mapper_ascii16.sv
verilog/mapper_output_mux.sv
verilog/msx_cart_mapper.sv
test/tb_msx_cart_mapper.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_msx_cart_mapper
RTL_TOP    := msx_cart_mapper
FILELIST   := msx_cart_mapper.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing --top-module $(RTL_TOP)
SIM_FLAGS  := --binary --timing --top-module $(TOP) --Mdir $(OBJ_DIR)
PASS_MSG   := TEST OK

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
